// File: design/ioi_macros.svh
`ifndef IOI_MACROS_SVH
`define IOI_MACROS_SVH

// bus widths
`define IOI_NPHYS 56
`define IOI_RV 64
`define IOI_NMASK 8
`define IOI_TIMER_W 64

`define IOI_NCPU 2
`define IOI_NCLIENTS 2

// cycles before the completion unit steps in
`define IOI_ADDR_TIMEOUT 16
`define IOI_DATA_TIMEOUT 4096

// timer window 0xffffffffff000000 - 0xffffffffff00ffff
`define IOI_TIMER_LSB 16
`define IOI_TIMER_BASE 40'hff_ffff_ff00

`endif

// File: design/io_bus_pkg.sv
`include "ioi_macros.svh"

package io_bus_pkg;

	typedef logic [`IOI_NPHYS-1:0] addr_t;
	typedef logic [`IOI_RV-1:0] data_t;
	typedef logic [`IOI_NMASK-1:0] mask_t;   // one bit per byte lane
	typedef logic [`IOI_NCLIENTS-1:0] client_vec_t;

endpackage

// File: design/io_map_pkg.sv
`include "ioi_macros.svh"

package io_map_pkg;

	// register index, address bits 15:3
	typedef enum logic [`IOI_TIMER_LSB-4:0] {
		TIMER_COUNT = 0,   // offset 0
		TIMER_CMP = 1      // offset 8, scratch compare
	} timer_reg_e;

	// an address split against the map
	typedef struct packed {
		logic [`IOI_NPHYS-1:`IOI_TIMER_LSB] region;
		timer_reg_e reg_sel;
		logic [2:0] byte_off;
	} map_addr_t;

endpackage

// File: design/io_bus_if.sv
`timescale 1ns/1ps
`include "ioi_macros.svh"

interface io_bus_if;

	logic addr_req;
	logic addr_ack;   // merged, forced included
	logic [`IOI_NPHYS-1:0] addr;
	logic read;
	logic [`IOI_NMASK-1:0] mask;
	logic [`IOI_RV-1:0] wdata;

	logic data_req;
	logic data_ack;
	logic [`IOI_RV-1:0] rdata;
	logic data_err;

	// the single local client
	logic local_addr_ack;
	logic local_data_req;
	logic [`IOI_RV-1:0] local_rdata;

	modport master (
		output addr_req, addr, read, mask, wdata, data_ack,
		input addr_ack, data_req, rdata, data_err
	);

	modport responder (
		output addr_ack, data_req, rdata, data_err,
		input addr_req, read, data_ack, local_addr_ack, local_data_req, local_rdata
	);

	modport client (
		input addr_req, addr, read, mask, wdata, data_ack,
		output local_addr_ack, local_data_req, local_rdata
	);

endinterface

// File: design/cpu_arbiter.sv
`timescale 1ns/1ps
`include "ioi_macros.svh"

module cpu_arbiter (
	input logic clk,
	input logic rst_n,
	input logic [`IOI_NCPU-1:0] cpu_addr_req,
	output logic [`IOI_NCPU-1:0] cpu_addr_ack,
	input io_bus_pkg::addr_t cpu_addr0,
	input io_bus_pkg::addr_t cpu_addr1,
	input logic [`IOI_NCPU-1:0] cpu_read,
	input logic [`IOI_NCPU-1:0] cpu_lock,
	input io_bus_pkg::mask_t cpu_mask0,
	input io_bus_pkg::mask_t cpu_mask1,
	input io_bus_pkg::data_t cpu_wdata0,
	input io_bus_pkg::data_t cpu_wdata1,
	output logic [`IOI_NCPU-1:0] cpu_data_req,
	input logic [`IOI_NCPU-1:0] cpu_data_ack,
	output io_bus_pkg::data_t cpu_rdata,
	output logic cpu_data_err,
	io_bus_if.master bus
);

	logic r_chosen;    // owner of the current or last address phase
	logic r_next;      // tie goes here
	logic r_pending;   // address phase waiting, keep the selection
	logic r_busy;      // read outstanding
	logic [`IOI_NCPU-1:0] r_read_locked;
	logic pick;
	logic sel;
	logic grant;

	always_comb begin
		pick = r_next;
		if (!cpu_addr_req[1])
			pick = 1'b0;
		else if (!cpu_addr_req[0])
			pick = 1'b1;
		else if (r_read_locked[0] != r_read_locked[1])
			pick = r_read_locked[1];   // locked cpu first
	end

	assign sel = r_pending ? r_chosen : pick;
	assign grant = bus.addr_req && bus.addr_ack;

	// address phase of the selected cpu
	assign bus.addr_req = |cpu_addr_req && !r_busy;
	assign bus.addr = sel ? cpu_addr1 : cpu_addr0;
	assign bus.read = cpu_read[sel];
	assign bus.mask = sel ? cpu_mask1 : cpu_mask0;
	assign bus.wdata = sel ? cpu_wdata1 : cpu_wdata0;

	assign cpu_addr_ack[0] = grant && !sel;
	assign cpu_addr_ack[1] = grant && sel;

	// data beat back to whoever was granted
	assign cpu_data_req[0] = bus.data_req && !r_chosen;
	assign cpu_data_req[1] = bus.data_req && r_chosen;
	assign bus.data_ack = cpu_data_ack[r_chosen];
	assign cpu_rdata = bus.rdata;
	assign cpu_data_err = bus.data_err;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_chosen <= 1'b0;
			r_next <= 1'b0;
			r_pending <= 1'b0;
			r_busy <= 1'b0;
			r_read_locked <= '0;
		end else begin
			r_pending <= bus.addr_req && !bus.addr_ack;
			if (bus.addr_req)
				r_chosen <= sel;
			if (grant) begin
				r_next <= !sel;
				if (bus.read) begin
					r_busy <= 1'b1;
					r_read_locked[sel] <= cpu_lock[sel];
				end
			end else if (bus.data_req && bus.data_ack) begin
				r_busy <= 1'b0;
			end
		end
	end

endmodule

// File: design/bus_completion.sv
`timescale 1ns/1ps
`include "ioi_macros.svh"

module bus_completion (
	input logic clk,
	input logic rst_n,
	io_bus_if.responder bus,
	input io_bus_pkg::client_vec_t ext_addr_ack,
	input io_bus_pkg::client_vec_t ext_data_req,
	input io_bus_pkg::data_t ext_rdata,
	input io_bus_pkg::client_vec_t ext_data_err
);

	localparam int ATW = $clog2(`IOI_ADDR_TIMEOUT + 1);
	localparam int DTW = $clog2(`IOI_DATA_TIMEOUT);

	logic [ATW-1:0] r_addr_timer;
	logic [DTW-1:0] r_data_timer;
	logic r_reading;      // read acked by a real client, data not seen yet
	logic r_force_beat;   // error beat standing in for missing data
	logic real_ack;
	logic force_ack;
	logic real_data;
	logic data_timeout;

	assign real_ack = |ext_addr_ack || bus.local_addr_ack;
	assign force_ack = bus.addr_req && !real_ack && r_addr_timer == ATW'(`IOI_ADDR_TIMEOUT);
	assign real_data = |ext_data_req || bus.local_data_req;
	assign data_timeout = r_reading && !real_data &&
		r_data_timer == DTW'(`IOI_DATA_TIMEOUT - 1);

	assign bus.addr_ack = real_ack || force_ack;
	assign bus.data_req = real_data || r_force_beat;
	assign bus.data_err = |(ext_data_err & ext_data_req) || r_force_beat;

	// local data wins over external
	always_comb begin
		if (bus.local_data_req)
			bus.rdata = bus.local_rdata;
		else if (|ext_data_req)
			bus.rdata = ext_rdata;
		else
			bus.rdata = '1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_addr_timer <= '0;
			r_data_timer <= '0;
			r_reading <= 1'b0;
			r_force_beat <= 1'b0;
		end else begin
			if (bus.addr_req && !bus.addr_ack)
				r_addr_timer <= r_addr_timer + 1'b1;
			else
				r_addr_timer <= '0;

			if (bus.addr_req && real_ack && bus.read)
				r_reading <= 1'b1;
			else if (real_data || data_timeout)
				r_reading <= 1'b0;

			// stops once any data shows up, so back-pressure never times out
			if (r_reading && !real_data)
				r_data_timer <= r_data_timer + 1'b1;
			else
				r_data_timer <= '0;

			if (r_force_beat && bus.data_ack)
				r_force_beat <= 1'b0;
			else if ((force_ack && bus.read) || data_timeout)
				r_force_beat <= 1'b1;
		end
	end

endmodule

// File: design/local_timer.sv
`timescale 1ns/1ps
`include "ioi_macros.svh"

module local_timer (
	input logic clk,
	input logic rst_n,
	io_bus_if.client bus,
	output logic [`IOI_TIMER_W-1:0] timer
);

	io_map_pkg::map_addr_t a;
	logic sel;
	logic wr;
	logic [`IOI_TIMER_W-1:0] r_count;
	logic [`IOI_TIMER_W-1:0] c_count;
	io_bus_pkg::data_t r_cmp;
	io_bus_pkg::data_t c_cmp;
	io_bus_pkg::data_t r_rdata;
	logic r_data_req;

	assign a = io_map_pkg::map_addr_t'(bus.addr);
	assign sel = bus.addr_req && a.region == `IOI_TIMER_BASE;
	assign wr = sel && !bus.read;

	assign bus.local_addr_ack = sel;   // same cycle
	assign bus.local_data_req = r_data_req;
	assign bus.local_rdata = r_rdata;
	assign timer = r_count;

	// a written count byte replaces the increment
	always_comb begin
		c_count = r_count + 1'b1;
		c_cmp = r_cmp;
		for (int i = 0; i < `IOI_NMASK; i++) begin
			if (wr && bus.mask[i]) begin
				if (a.reg_sel == io_map_pkg::TIMER_COUNT)
					c_count[8*i +: 8] = bus.wdata[8*i +: 8];
				else if (a.reg_sel == io_map_pkg::TIMER_CMP)
					c_cmp[8*i +: 8] = bus.wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_count <= '0;
			r_cmp <= '0;
			r_data_req <= 1'b0;
		end else begin
			r_count <= c_count;
			r_cmp <= c_cmp;
			if (sel && bus.read)
				r_data_req <= 1'b1;
			else if (r_data_req && bus.data_ack)
				r_data_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sel && bus.read) begin
			case (a.reg_sel)
			io_map_pkg::TIMER_COUNT: r_rdata <= r_count;
			io_map_pkg::TIMER_CMP: r_rdata <= r_cmp;
			default: r_rdata <= '0;   // holes read as zero
			endcase
		end
	end

endmodule

// File: design/ioi_top.sv
`timescale 1ns/1ps
`include "ioi_macros.svh"

module ioi_top (
	input logic clk,
	input logic rst_n,

	input logic cpu_addr_req_0,
	output logic cpu_addr_ack_0,
	input io_bus_pkg::addr_t cpu_addr_0,
	input logic cpu_read_0,
	input logic cpu_lock_0,
	input io_bus_pkg::mask_t cpu_mask_0,
	input io_bus_pkg::data_t cpu_wdata_0,
	output logic cpu_data_req_0,
	input logic cpu_data_ack_0,
	output io_bus_pkg::data_t cpu_rdata_0,
	output logic cpu_data_err_0,

	input logic cpu_addr_req_1,
	output logic cpu_addr_ack_1,
	input io_bus_pkg::addr_t cpu_addr_1,
	input logic cpu_read_1,
	input logic cpu_lock_1,
	input io_bus_pkg::mask_t cpu_mask_1,
	input io_bus_pkg::data_t cpu_wdata_1,
	output logic cpu_data_req_1,
	input logic cpu_data_ack_1,
	output io_bus_pkg::data_t cpu_rdata_1,
	output logic cpu_data_err_1,

	output logic io_addr_req,
	input io_bus_pkg::client_vec_t io_addr_ack,
	output io_bus_pkg::addr_t io_addr,
	output logic io_read,
	output io_bus_pkg::mask_t io_mask,
	output io_bus_pkg::data_t io_wdata,
	input io_bus_pkg::client_vec_t io_data_req,
	output logic io_data_ack,
	input io_bus_pkg::data_t io_rdata,
	input io_bus_pkg::client_vec_t io_data_err,

	output logic [`IOI_TIMER_W-1:0] io_timer
);

	io_bus_if bus ();

	cpu_arbiter cpu_arbiter_inst (
		.clk(clk), .rst_n(rst_n),
		.cpu_addr_req({cpu_addr_req_1, cpu_addr_req_0}),
		.cpu_addr_ack({cpu_addr_ack_1, cpu_addr_ack_0}),
		.cpu_addr0(cpu_addr_0), .cpu_addr1(cpu_addr_1),
		.cpu_read({cpu_read_1, cpu_read_0}),
		.cpu_lock({cpu_lock_1, cpu_lock_0}),
		.cpu_mask0(cpu_mask_0), .cpu_mask1(cpu_mask_1),
		.cpu_wdata0(cpu_wdata_0), .cpu_wdata1(cpu_wdata_1),
		.cpu_data_req({cpu_data_req_1, cpu_data_req_0}),
		.cpu_data_ack({cpu_data_ack_1, cpu_data_ack_0}),
		.cpu_rdata(cpu_rdata_0),
		.cpu_data_err(cpu_data_err_0),
		.bus(bus.master)
	);

	// both cpus see the same beat, data_req says whose it is
	assign cpu_rdata_1 = cpu_rdata_0;
	assign cpu_data_err_1 = cpu_data_err_0;

	bus_completion bus_completion_inst (
		.clk(clk), .rst_n(rst_n),
		.bus(bus.responder),
		.ext_addr_ack(io_addr_ack),
		.ext_data_req(io_data_req),
		.ext_rdata(io_rdata),
		.ext_data_err(io_data_err)
	);

	local_timer local_timer_inst (
		.clk(clk), .rst_n(rst_n),
		.bus(bus.client),
		.timer(io_timer)
	);

	assign io_addr_req = bus.addr_req;
	assign io_addr = bus.addr;
	assign io_read = bus.read;
	assign io_mask = bus.mask;
	assign io_wdata = bus.wdata;
	assign io_data_ack = bus.data_ack;

endmodule

// File: testbench/ioi_tb.sv
`timescale 1ns/1ps
`include "ioi_macros.svh"

module ioi_tb;

	localparam io_bus_pkg::addr_t COUNT_ADDR = {`IOI_TIMER_BASE, 16'h0000};
	localparam io_bus_pkg::addr_t CMP_ADDR = {`IOI_TIMER_BASE, 16'h0008};
	localparam io_bus_pkg::addr_t EXT_ADDR = 56'h00_0000_1000_0040;
	localparam io_bus_pkg::addr_t HOLE_ADDR = 56'h00_00a0_0000_0100;   // nobody answers here

	logic clk = 1'b0;
	logic rst_n;
	logic [1:0] addr_req;
	logic [1:0] read;
	logic [1:0] lock;
	logic [1:0] data_ack;
	io_bus_pkg::addr_t addr [2];
	io_bus_pkg::mask_t mask [2];
	io_bus_pkg::data_t wdata [2];
	wire [1:0] addr_ack;
	wire [1:0] data_req;
	wire [1:0] data_err;
	wire [`IOI_RV-1:0] rdata [2];
	io_bus_pkg::client_vec_t ext_addr_ack;
	io_bus_pkg::client_vec_t ext_data_req;
	io_bus_pkg::client_vec_t ext_data_err;
	io_bus_pkg::data_t ext_rdata;
	wire io_addr_req;
	wire io_read;
	wire io_data_ack;
	wire [`IOI_NPHYS-1:0] io_addr;
	wire [`IOI_NMASK-1:0] io_mask;
	wire [`IOI_RV-1:0] io_wdata;
	wire [`IOI_TIMER_W-1:0] io_timer;

	int cycle = 0;
	int errors = 0;
	int tests = 0;
	integer seed = 32'h047d_b646;
	logic log_grants = 1'b0;
	int grant_log[$];
	io_bus_pkg::addr_t seen_addr;   // last address phase an external client took
	io_bus_pkg::mask_t seen_mask;
	io_bus_pkg::data_t seen_wdata;
	logic seen_read;

	ioi_top ioi_top_inst (
		.clk(clk), .rst_n(rst_n),
		.cpu_addr_req_0(addr_req[0]), .cpu_addr_ack_0(addr_ack[0]),
		.cpu_addr_0(addr[0]), .cpu_read_0(read[0]), .cpu_lock_0(lock[0]),
		.cpu_mask_0(mask[0]), .cpu_wdata_0(wdata[0]),
		.cpu_data_req_0(data_req[0]), .cpu_data_ack_0(data_ack[0]),
		.cpu_rdata_0(rdata[0]), .cpu_data_err_0(data_err[0]),
		.cpu_addr_req_1(addr_req[1]), .cpu_addr_ack_1(addr_ack[1]),
		.cpu_addr_1(addr[1]), .cpu_read_1(read[1]), .cpu_lock_1(lock[1]),
		.cpu_mask_1(mask[1]), .cpu_wdata_1(wdata[1]),
		.cpu_data_req_1(data_req[1]), .cpu_data_ack_1(data_ack[1]),
		.cpu_rdata_1(rdata[1]), .cpu_data_err_1(data_err[1]),
		.io_addr_req(io_addr_req), .io_addr_ack(ext_addr_ack),
		.io_addr(io_addr), .io_read(io_read), .io_mask(io_mask), .io_wdata(io_wdata),
		.io_data_req(ext_data_req), .io_data_ack(io_data_ack),
		.io_rdata(ext_rdata), .io_data_err(ext_data_err),
		.io_timer(io_timer)
	);

	always #2 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic io_bus_pkg::data_t next_random();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic check_equal(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic give_up(input string why);
		$display("%0t: %s", $time, why);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - errs_before);
	endtask

	// one cpu transaction, cycle numbers of request, acknowledge and data beat
	task automatic cpu_access(input int c, input io_bus_pkg::addr_t a, input logic rd,
			input logic lk, input io_bus_pkg::mask_t m, input io_bus_pkg::data_t wd,
			output io_bus_pkg::data_t rv, output logic err, output int t_req,
			output int t_ack, output int t_data);
		int n;
		rv = '0;
		err = 1'b0;
		t_data = 0;
		@(posedge clk);
		#1;
		addr_req[c] = 1'b1;
		addr[c] = a;
		read[c] = rd;
		lock[c] = lk;
		mask[c] = m;
		wdata[c] = wd;
		@(negedge clk);
		t_req = cycle;
		n = 0;
		while (!addr_ack[c] && n < 4 * `IOI_ADDR_TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		t_ack = cycle;
		if (!addr_ack[c]) begin
			give_up($sformatf("cpu %0d address phase was never acknowledged", c));
		end else begin
			@(posedge clk);
			#1;
			addr_req[c] = 1'b0;
			if (rd) begin
				n = 0;
				@(negedge clk);
				while (!data_req[c] && n < `IOI_DATA_TIMEOUT + 64) begin
					n++;
					@(negedge clk);
				end
				if (!data_req[c]) begin
					give_up($sformatf("cpu %0d read never got a data beat", c));
				end else begin
					t_data = cycle;
					rv = rdata[c];
					err = data_err[c];
					check_equal($sformatf("cpu_data_req_%0d", 1 - c), data_req[1 - c], 1'b0);
				end
			end
		end
	endtask

	// external client k takes count address phases, reads get beat unless send_data is low
	task automatic serve_client(input int k, input int count, input logic send_data,
			input io_bus_pkg::data_t beat);
		int n;
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < count && ok; i++) begin
			n = 0;
			@(negedge clk);
			while (!io_addr_req && n < 64) begin
				n++;
				@(negedge clk);
			end
			if (!io_addr_req) begin
				ok = 1'b0;
				give_up($sformatf("client %0d saw no address request", k));
			end else begin
				@(posedge clk);
				#1;
				ext_addr_ack[k] = 1'b1;
				@(negedge clk);
				seen_addr = io_addr;
				seen_mask = io_mask;
				seen_wdata = io_wdata;
				seen_read = io_read;
				@(posedge clk);
				#1;
				ext_addr_ack[k] = 1'b0;
				if (seen_read && send_data) begin
					ext_data_req[k] = 1'b1;
					ext_rdata = beat;
					n = 0;
					@(negedge clk);
					while (!io_data_ack && n < 64) begin
						n++;
						@(negedge clk);
					end
					if (!io_data_ack) begin
						ok = 1'b0;
						give_up($sformatf("client %0d data beat was never taken", k));
					end else begin
						@(posedge clk);
						#1;
						ext_data_req[k] = 1'b0;
					end
				end
			end
		end
	endtask

	// bus checks on every cycle
	always @(negedge clk) begin
		if (rst_n) begin
			assert (addr_ack != 2'b11) else begin
				errors++;
				$display("%0t: both cpus acknowledged in one cycle", $time);
			end
			assert (data_req != 2'b11) else begin
				errors++;
				$display("%0t: data beat routed to both cpus", $time);
			end
			for (int c = 0; c < 2; c++) begin
				if (addr_ack[c]) begin
					assert (addr_req[c]) else begin
						errors++;
						$display("%0t: cpu %0d acknowledged without a request", $time, c);
					end
					check_equal("io_addr", io_addr, addr[c]);
					check_equal("io_read", io_read, read[c]);
					check_equal("io_mask", io_mask, mask[c]);
					if (!read[c])
						check_equal("io_wdata", io_wdata, wdata[c]);
				end
			end
			if (log_grants && addr_ack != 2'b00)
				grant_log.push_back(addr_ack[1]);
		end
	end

	initial begin
		io_bus_pkg::data_t rv;
		io_bus_pkg::data_t rv1;
		io_bus_pkg::data_t w;
		io_bus_pkg::data_t cmp;
		io_bus_pkg::data_t part;
		logic err;
		logic err1;
		int tr, ta, td, tr1, ta1, td1, t_wr;
		int mark;

		rst_n = 1'b0;
		addr_req = '0;
		read = '0;
		lock = '0;
		data_ack = 2'b11;   // cpus always take the beat
		for (int c = 0; c < 2; c++) begin
			addr[c] = '0;
			mask[c] = '0;
			wdata[c] = '0;
		end
		ext_addr_ack = '0;
		ext_data_req = '0;
		ext_data_err = '0;
		ext_rdata = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		mark = errors;
		@(negedge clk);
		check_equal("cpu_addr_ack", addr_ack, '0);
		check_equal("cpu_data_req", data_req, '0);
		check_equal("io_timer", io_timer, '0);
		repeat (4) begin
			w = io_timer;
			@(negedge clk);
			check_equal("io_timer", io_timer, w + 1);
		end
		close_test("reset state", mark);

		mark = errors;
		w = next_random();
		cmp = next_random();
		part = next_random();
		cpu_access(0, COUNT_ADDR, 1'b0, 1'b0, 8'hff, w, rv, err, tr, t_wr, td);
		@(negedge clk);
		check_equal("io_timer", io_timer, w);
		cpu_access(0, CMP_ADDR, 1'b0, 1'b0, 8'hff, cmp, rv, err, tr, ta, td);
		cpu_access(0, CMP_ADDR, 1'b0, 1'b0, 8'h0f, part, rv, err, tr, ta, td);   // low half only
		cpu_access(0, COUNT_ADDR, 1'b1, 1'b0, 8'hff, '0, rv, err, tr, ta, td);
		check_equal("cpu_rdata_0", rv, w + 64'(ta - t_wr - 1));
		check_equal("cpu_data_err_0", err, 1'b0);
		cpu_access(0, CMP_ADDR, 1'b1, 1'b0, 8'hff, '0, rv, err, tr, ta, td);
		check_equal("cpu_rdata_0", rv, {cmp[63:32], part[31:0]});
		check_equal("cpu_data_err_0", err, 1'b0);
		close_test("timer write and read", mark);

		mark = errors;
		w = next_random();
		fork
			cpu_access(1, EXT_ADDR, 1'b0, 1'b0, 8'h3c, w, rv, err, tr, ta, td);
			serve_client(0, 1, 1'b1, '0);
		join
		check_equal("io_addr", seen_addr, EXT_ADDR);
		check_equal("io_mask", seen_mask, 8'h3c);
		check_equal("io_wdata", seen_wdata, w);
		check_equal("io_read", seen_read, 1'b0);
		w = next_random();
		fork
			cpu_access(1, EXT_ADDR + 8, 1'b1, 1'b0, 8'hff, '0, rv, err, tr, ta, td);
			serve_client(1, 1, 1'b1, w);
		join
		check_equal("io_addr", seen_addr, EXT_ADDR + 8);
		check_equal("io_read", seen_read, 1'b1);
		check_equal("cpu_rdata_1", rv, w);
		check_equal("cpu_data_err_1", err, 1'b0);
		close_test("external transactions", mark);

		mark = errors;
		for (int i = 0; i < 4; i++) begin
			fork   // a lone access decides whose turn it is
				cpu_access(i % 2, EXT_ADDR, 1'b0, 1'b0, 8'hff, next_random(),
					rv, err, tr, ta, td);
				serve_client(0, 1, 1'b0, '0);
			join
			grant_log.delete();
			log_grants = 1'b1;
			fork
				cpu_access(0, EXT_ADDR, 1'b0, 1'b0, 8'hff, next_random(),
					rv, err, tr, ta, td);
				cpu_access(1, EXT_ADDR + 16, 1'b0, 1'b0, 8'hff, next_random(),
					rv1, err1, tr1, ta1, td1);
				serve_client(0, 2, 1'b0, '0);
			join
			log_grants = 1'b0;
			if (grant_log.size() != 2) begin
				errors++;
				$display("%0t: contest %0d gave %0d grants instead of 2",
					$time, i, grant_log.size());
			end else begin
				check_equal("first grant", grant_log[0], 1 - i % 2);
				check_equal("second grant", grant_log[1], i % 2);
			end
		end
		w = next_random();
		fork
			cpu_access(0, EXT_ADDR, 1'b1, 1'b1, 8'hff, '0, rv, err, tr, ta, td);   // locked
			serve_client(1, 1, 1'b1, w);
		join
		check_equal("cpu_rdata_0", rv, w);
		grant_log.delete();
		log_grants = 1'b1;
		fork
			cpu_access(0, EXT_ADDR, 1'b0, 1'b0, 8'hff, next_random(), rv, err, tr, ta, td);
			cpu_access(1, EXT_ADDR + 16, 1'b0, 1'b0, 8'hff, next_random(),
				rv1, err1, tr1, ta1, td1);
			serve_client(0, 2, 1'b0, '0);
		join
		log_grants = 1'b0;
		check_equal("grant count", grant_log.size(), 2);
		if (grant_log.size() > 0)
			check_equal("first grant after lock", grant_log[0], 0);
		close_test("arbitration", mark);

		mark = errors;
		cpu_access(0, HOLE_ADDR, 1'b1, 1'b0, 8'hff, '0, rv, err, tr, ta, td);
		check_equal("address timeout delay", ta - tr, `IOI_ADDR_TIMEOUT);
		check_equal("fake beat delay", td - ta, 1);
		check_equal("cpu_data_err_0", err, 1'b1);
		close_test("address timeout", mark);

		mark = errors;
		fork
			cpu_access(1, EXT_ADDR + 8, 1'b1, 1'b0, 8'hff, '0, rv, err, tr, ta, td);
			serve_client(0, 1, 1'b0, '0);   // acks, never sends data
		join
		assert (td - ta >= `IOI_DATA_TIMEOUT - 1 && td - ta <= `IOI_DATA_TIMEOUT + 1) else begin
			errors++;
			$display("ERR %0t data timeout delay got %0d expected %0d +-1",
				$time, td - ta, `IOI_DATA_TIMEOUT);
		end
		check_equal("cpu_data_err_1", err, 1'b1);
		close_test("data timeout", mark);

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+design
design/io_bus_pkg.sv
design/io_map_pkg.sv
design/io_bus_if.sv
design/cpu_arbiter.sv
design/bus_completion.sv
design/local_timer.sv
design/ioi_top.sv
testbench/ioi_tb.sv
